// File: dv/lru_checker.sv
`timescale 1ns/1ps

module lru_checker (
  input logic               clk,
  input logic               rstN,
  input logic               reqValid,
  input logic               rspValid,
  input logic               stValid,
  input lru_geom_pkg::agesT stAges
);

  localparam int WayBits = lru_geom_pkg::WayBits;

  // every age value 0..Ways-1 seen once
  function automatic logic agesDistinct(lru_geom_pkg::agesT ages);
    logic [lru_geom_pkg::Ways-1:0] seen;
    seen = '0;
    for (int k = 0; k < lru_geom_pkg::Ways; k++) begin
      seen[ages[k*WayBits +: WayBits]] = 1'b1;
    end
    return &seen;
  endfunction

  rspLatency: assert property (@(posedge clk) disable iff (!rstN)
    rspValid == $past(reqValid, 3))  // decode, execute, result
    else $error("rspValid does not follow reqValid by 3 cycles");

  rspResetLow: assert property (@(posedge clk)
    !rstN |=> !rspValid)
    else $error("rspValid high after a reset cycle");

  agesPermutation: assert property (@(posedge clk) disable iff (!rstN)
    stValid |-> agesDistinct(stAges))
    else $error("stAges holds a repeated age");

endmodule

bind lru_top lru_checker uChecker (
  .clk      (clk),
  .rstN     (rstN),
  .reqValid (reqValid),
  .rspValid (rspValid),
  .stValid  (stValid),
  .stAges   (stAges)
);

// File: dv/lru_tb.sv
`timescale 1ns/1ps

module lru_tb;

  localparam int unsigned Seed = 32'h7d1991a9;
  localparam int Ways          = lru_geom_pkg::Ways;
  localparam int Sets          = lru_geom_pkg::Sets;
  localparam int ResetCycles   = 5;
  localparam int TouchIters    = 100;  // touch then query
  localparam int PairIters     = 40;   // 5 requests each
  localparam int SameIters     = 40;   // equal-way pair then query
  localparam int InitIters     = 20;   // 4 requests each
  localparam int BurstBlocks   = 10;
  localparam int BurstLen      = 20;
  localparam int DrainCycles   = 4;
  localparam int NumPhases     = 6;
  localparam int TotalReqs     = Sets + 2 * TouchIters + 5 * PairIters + 2 * SameIters
                                 + 4 * InitIters + BurstBlocks * BurstLen;
  localparam int StimCycles    = ResetCycles + TotalReqs + NumPhases * DrainCycles;
  localparam int TimeoutCycles = 2 * StimCycles + 50;

  logic              clk;
  logic              rstN;
  logic              reqValid;
  lru_op_pkg::opT    reqOp;
  lru_geom_pkg::setT reqSet;
  lru_geom_pkg::wayT reqWayA;
  lru_geom_pkg::wayT reqWayB;
  logic              rspValid;
  lru_geom_pkg::setT rspSet;
  lru_geom_pkg::wayT rspVictim;

  // recency list per set with index 0 most recent
  lru_geom_pkg::wayT order [Sets][Ways];
  lru_geom_pkg::setT expSet [$];
  lru_geom_pkg::wayT expVictim [$];
  int                reqCycle [$];
  int                cycleCount;
  int                latency;

  lru_top u_dut (
    .clk       (clk),
    .rstN      (rstN),
    .reqValid  (reqValid),
    .reqOp     (reqOp),
    .reqSet    (reqSet),
    .reqWayA   (reqWayA),
    .reqWayB   (reqWayB),
    .rspValid  (rspValid),
    .rspSet    (rspSet),
    .rspVictim (rspVictim)
  );

  always #2 clk = ~clk;

  task automatic stopWithFailure();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic checkSet(lru_geom_pkg::setT got, lru_geom_pkg::setT exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: rspSet is %0d, expected %0d", $time, got, exp);
      stopWithFailure();
    end
  endtask

  task automatic checkVictim(lru_geom_pkg::wayT got, lru_geom_pkg::wayT exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: rspVictim is %0d, expected %0d", $time, got, exp);
      stopWithFailure();
    end
  endtask

  function automatic lru_geom_pkg::setT randSet();
    return lru_geom_pkg::setT'($urandom_range(Sets - 1));
  endfunction

  function automatic lru_geom_pkg::wayT randWay();
    return lru_geom_pkg::wayT'($urandom_range(Ways - 1));
  endfunction

  task automatic restoreOrder(lru_geom_pkg::setT s);
    for (int i = 0; i < Ways; i++) begin
      order[s][i] = lru_geom_pkg::wayT'(i);
    end
  endtask

  // move one way to the head of the list
  task automatic moveToFront(lru_geom_pkg::setT s, lru_geom_pkg::wayT w);
    int pos;
    pos = 0;
    for (int i = 0; i < Ways; i++) begin
      if (order[s][i] == w) pos = i;
    end
    for (int i = pos; i > 0; i--) begin
      order[s][i] = order[s][i-1];
    end
    order[s][0] = w;
  endtask

  task automatic applyToModel(lru_op_pkg::opT op, lru_geom_pkg::setT s,
                              lru_geom_pkg::wayT a, lru_geom_pkg::wayT b);
    case (op)
      lru_op_pkg::OpTouch: begin
        moveToFront(s, a);
      end
      lru_op_pkg::OpPair: begin
        moveToFront(s, b);
        moveToFront(s, a);  // equal ways end up as one touch
      end
      lru_op_pkg::OpInit: begin
        restoreOrder(s);
      end
      default: begin
      end
    endcase
  endtask

  task automatic sendReq(lru_op_pkg::opT op, lru_geom_pkg::setT s,
                         lru_geom_pkg::wayT a, lru_geom_pkg::wayT b);
    @(posedge clk);
    reqValid <= 1'b1;
    reqOp    <= op;
    reqSet   <= s;
    reqWayA  <= a;
    reqWayB  <= b;
    applyToModel(op, s, a, b);
    expSet.push_back(s);
    expVictim.push_back(order[s][Ways-1]);
    reqCycle.push_back(cycleCount + 1);  // DUT samples at the next edge
  endtask

  task automatic drainResponses();
    @(posedge clk);
    reqValid <= 1'b0;
    while (expSet.size() != 0) begin
      @(negedge clk);
    end
  endtask

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      $display("timeout: no end of test after %0d cycles", TimeoutCycles);
      stopWithFailure();
    end
  end

  // response monitor in request order
  always @(posedge clk) begin
    if (rstN && rspValid) begin
      if (expSet.size() == 0) begin
        $display("response at %0t without any outstanding request", $time);
        stopWithFailure();
      end else begin
        checkSet(rspSet, expSet.pop_front());
        checkVictim(rspVictim, expVictim.pop_front());
        latency = cycleCount - reqCycle.pop_front();
        if (latency != 3) begin
          $display("response at %0t came %0d cycles after its request", $time, latency);
          stopWithFailure();
        end
      end
    end
  end

  initial begin
    lru_geom_pkg::setT s;
    lru_geom_pkg::setT t;
    lru_geom_pkg::wayT a;
    lru_geom_pkg::wayT b;
    lru_geom_pkg::wayT c;
    lru_geom_pkg::wayT d;
    clk        = 1'b0;
    rstN       = 1'b0;
    reqValid   = 1'b0;
    reqOp      = lru_op_pkg::OpQuery;
    reqSet     = '0;
    reqWayA    = '0;
    reqWayB    = '0;
    cycleCount = 0;
    void'($urandom(Seed));
    for (int i = 0; i < Sets; i++) begin
      restoreOrder(lru_geom_pkg::setT'(i));
    end
    repeat (ResetCycles) @(posedge clk);
    rstN <= 1'b1;

    // every set starts with victim 3
    for (int i = 0; i < Sets; i++) begin
      sendReq(lru_op_pkg::OpQuery, lru_geom_pkg::setT'(i), '0, '0);
    end
    drainResponses();

    for (int i = 0; i < TouchIters; i++) begin
      s = randSet();
      sendReq(lru_op_pkg::OpTouch, s, randWay(), randWay());
      sendReq(lru_op_pkg::OpQuery, s, randWay(), randWay());
    end
    drainResponses();

    // touching the other two ways exposes b and then a
    for (int i = 0; i < PairIters; i++) begin
      s = randSet();
      a = randWay();
      b = a + lru_geom_pkg::wayT'(1 + $urandom_range(2));
      c = a;
      d = a;
      for (int k = 0; k < Ways; k++) begin
        if (lru_geom_pkg::wayT'(k) != a && lru_geom_pkg::wayT'(k) != b) begin
          if (c == a) c = lru_geom_pkg::wayT'(k);
          else d = lru_geom_pkg::wayT'(k);
        end
      end
      sendReq(lru_op_pkg::OpPair, s, a, b);
      sendReq(lru_op_pkg::OpQuery, s, a, b);
      sendReq(lru_op_pkg::OpTouch, s, c, c);
      sendReq(lru_op_pkg::OpTouch, s, d, d);
      sendReq(lru_op_pkg::OpTouch, s, b, b);
    end
    drainResponses();

    for (int i = 0; i < SameIters; i++) begin
      s = randSet();
      a = randWay();
      sendReq(lru_op_pkg::OpPair, s, a, a);
      sendReq(lru_op_pkg::OpQuery, s, randWay(), randWay());
    end
    drainResponses();

    // init one set while its neighbour keeps its order
    for (int i = 0; i < InitIters; i++) begin
      s = randSet();
      t = s + lru_geom_pkg::setT'(1 + $urandom_range(Sets - 2));
      sendReq(lru_op_pkg::OpTouch, s, randWay(), randWay());
      sendReq(lru_op_pkg::OpTouch, t, randWay(), randWay());
      sendReq(lru_op_pkg::OpInit, s, randWay(), randWay());
      sendReq(lru_op_pkg::OpQuery, t, randWay(), randWay());
    end
    drainResponses();

    // back to back on one set
    for (int i = 0; i < BurstBlocks; i++) begin
      s = randSet();
      for (int j = 0; j < BurstLen; j++) begin
        sendReq(lru_op_pkg::opT'($urandom_range(3)), s, randWay(), randWay());
      end
    end
    drainResponses();

    // a stray response in these cycles still trips the monitor
    repeat (2) @(posedge clk);
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: source/lru_age_update.sv
`timescale 1ns/1ps

module lru_age_update (
  input  lru_geom_pkg::ageT age,      // current age of this way
  input  lru_op_pkg::opT    op,
  input  lru_geom_pkg::wayT wayA,
  input  lru_geom_pkg::wayT wayB,
  input  lru_geom_pkg::ageT hitAgeA,  // current age of wayA
  input  lru_geom_pkg::ageT hitAgeB,  // current age of wayB
  input  lru_geom_pkg::wayT way,      // index of this way
  output lru_geom_pkg::ageT newAge
);

  logic              isWayA;
  logic              isWayB;
  logic              youngerA;  // more recent than wayA
  logic              youngerB;  // more recent than wayB
  lru_geom_pkg::ageT ageInc1;
  lru_geom_pkg::ageT pairBump;  // 0, 1 or 2

  assign isWayA   = (way == wayA);
  assign isWayB   = (way == wayB);
  assign youngerA = (age < hitAgeA);
  assign youngerB = (age < hitAgeB);

  assign ageInc1  = age + lru_geom_pkg::ageT'(1);
  assign pairBump = lru_geom_pkg::ageT'(youngerA) + lru_geom_pkg::ageT'(youngerB);

  always_comb begin
    newAge = age;  // query and idle keep the age
    case (op)
      lru_op_pkg::OpInit: begin
        newAge = way;  // way k back to age k
      end
      lru_op_pkg::OpTouch: begin
        if (isWayA) begin
          newAge = '0;
        end else if (youngerA) begin
          newAge = ageInc1;  // slides back behind the hit way
        end
      end
      lru_op_pkg::OpPair: begin
        // decode guarantees wayA != wayB here
        if (isWayA) begin
          newAge = '0;
        end else if (isWayB) begin
          newAge = lru_geom_pkg::ageT'(1);
        end else begin
          // younger than both moves by two, than one by one
          newAge = age + pairBump;
        end
      end
      default: begin
        newAge = age;
      end
    endcase
  end

endmodule

// File: source/lru_decode.sv
`timescale 1ns/1ps

module lru_decode (
  input  logic              clk,
  input  logic              rstN,
  input  logic              reqValid,
  input  lru_op_pkg::opT    reqOp,
  input  lru_geom_pkg::setT reqSet,
  input  lru_geom_pkg::wayT reqWayA,
  input  lru_geom_pkg::wayT reqWayB,
  lru_op_if.src             op
);

  logic           samePair;  // pair naming the same way twice
  lru_op_pkg::opT decOp;

  assign samePair = (reqOp == lru_op_pkg::OpPair) && (reqWayA == reqWayB);

  // a degenerate pair is just a touch of wayA
  assign decOp = samePair ? lru_op_pkg::OpTouch : reqOp;

  // strobe register
  always_ff @(posedge clk) begin
    if (!rstN) begin
      op.valid <= 1'b0;
    end else begin
      op.valid <= reqValid;
    end
  end

  // payload only moves on a real request
  always_ff @(posedge clk) begin
    if (reqValid) begin
      op.op   <= decOp;
      op.set  <= reqSet;
      op.wayA <= reqWayA;
      op.wayB <= reqWayB;  // don't care after re-coding
    end
  end

endmodule

// File: source/lru_execute.sv
`timescale 1ns/1ps

module lru_execute (
  input  logic               clk,
  input  logic               rstN,
  lru_op_if.dst              op,
  output logic               stValid,
  output lru_geom_pkg::setT  stSet,
  output lru_geom_pkg::agesT stAges
);

  localparam int WayBits = lru_geom_pkg::WayBits;

  lru_geom_pkg::agesT ageMem [lru_geom_pkg::Sets];  // one age vector per set

  lru_geom_pkg::agesT rdAges;   // ages of the addressed set
  lru_geom_pkg::agesT newAges;  // ages after this request
  lru_geom_pkg::ageT  hitAgeA;
  lru_geom_pkg::ageT  hitAgeB;

  // combinational read, so a write at the last edge is seen now
  assign rdAges  = ageMem[op.set];
  assign hitAgeA = rdAges[op.wayA*WayBits +: WayBits];
  assign hitAgeB = rdAges[op.wayB*WayBits +: WayBits];

  // one updater per way, all see the same hit ages
  for (genvar k = 0; k < lru_geom_pkg::Ways; k++) begin : genWay
    lru_age_update uAgeUpdate (
      .age     (rdAges[k*WayBits +: WayBits]),
      .op      (op.op),
      .wayA    (op.wayA),
      .wayB    (op.wayB),
      .hitAgeA (hitAgeA),
      .hitAgeB (hitAgeB),
      .way     (lru_geom_pkg::wayT'(k)),
      .newAge  (newAges[k*WayBits +: WayBits])
    );
  end

  // age array, every set starts in init order
  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int s = 0; s < lru_geom_pkg::Sets; s++) begin
        ageMem[s] <= lru_geom_pkg::InitAges;
      end
    end else if (op.valid) begin
      ageMem[op.set] <= newAges;
    end
  end

  // result strobe
  always_ff @(posedge clk) begin
    if (!rstN) begin
      stValid <= 1'b0;
    end else begin
      stValid <= op.valid;
    end
  end

  // same edge as the array write
  always_ff @(posedge clk) begin
    if (op.valid) begin
      stSet  <= op.set;
      stAges <= newAges;
    end
  end

endmodule

// File: source/lru_geom_pkg.sv
package lru_geom_pkg;

  // cache geometry
  localparam int Ways    = 4;
  localparam int Sets    = 16;
  localparam int WayBits = 2;  // log2(Ways)
  localparam int SetBits = 4;  // log2(Sets)

  // way index, also wide enough for one age
  typedef logic [WayBits-1:0] wayT;

  // 0 = most recent, Ways-1 = victim
  typedef logic [WayBits-1:0] ageT;

  typedef logic [SetBits-1:0] setT;

  // ages of one set, way k in slice k
  typedef logic [Ways*WayBits-1:0] agesT;

  // way k holds age k, so way 3 starts out as victim
  localparam agesT InitAges = {
    ageT'(3),
    ageT'(2),
    ageT'(1),
    ageT'(0)
  };

endpackage

// File: source/lru_op_if.sv
`timescale 1ns/1ps

interface lru_op_if;

  logic                valid;  // one-cycle strobe
  lru_op_pkg::opT      op;     // never a degenerate pair
  lru_geom_pkg::setT   set;
  lru_geom_pkg::wayT   wayA;   // hit way, or first way of pair
  lru_geom_pkg::wayT   wayB;   // second way of pair

  // decode side
  modport src (
    output valid,
    output op,
    output set,
    output wayA,
    output wayB
  );

  // execute side
  modport dst (
    input valid,
    input op,
    input set,
    input wayA,
    input wayB
  );

endinterface

// File: source/lru_op_pkg.sv
package lru_op_pkg;

  // request opcode
  typedef logic [1:0] opT;

  // read victim only, no update
  localparam opT OpQuery = 2'd0;

  // one hit way becomes most recent
  localparam opT OpTouch = 2'd1;

  // wayA most recent, wayB next
  localparam opT OpPair  = 2'd2;

  // restore initial order of the set
  localparam opT OpInit  = 2'd3;

endpackage

// File: source/lru_result.sv
`timescale 1ns/1ps

module lru_result (
  input  logic               clk,
  input  logic               rstN,
  input  logic               stValid,
  input  lru_geom_pkg::setT  stSet,
  input  lru_geom_pkg::agesT stAges,
  output logic               rspValid,
  output lru_geom_pkg::setT  rspSet,
  output lru_geom_pkg::wayT  rspVictim
);

  localparam int WayBits = lru_geom_pkg::WayBits;
  localparam lru_geom_pkg::ageT OldestAge = lru_geom_pkg::ageT'(lru_geom_pkg::Ways - 1);

  lru_geom_pkg::wayT victim;

  // exactly one way holds the oldest age
  always_comb begin
    victim = '0;
    for (int k = 0; k < lru_geom_pkg::Ways; k++) begin
      if (stAges[k*WayBits +: WayBits] == OldestAge) begin
        victim = lru_geom_pkg::wayT'(k);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      rspValid <= 1'b0;
    end else begin
      rspValid <= stValid;
    end
  end

  // response payload
  always_ff @(posedge clk) begin
    if (stValid) begin
      rspSet    <= stSet;
      rspVictim <= victim;
    end
  end

endmodule

// File: source/lru_top.sv
`timescale 1ns/1ps

module lru_top (
  input  logic              clk,
  input  logic              rstN,
  // request, one-cycle strobe, never stalled
  input  logic              reqValid,
  input  lru_op_pkg::opT    reqOp,
  input  lru_geom_pkg::setT reqSet,
  input  lru_geom_pkg::wayT reqWayA,
  input  lru_geom_pkg::wayT reqWayB,
  // response, 3 cycles after request
  output logic              rspValid,
  output lru_geom_pkg::setT rspSet,
  output lru_geom_pkg::wayT rspVictim
);

  lru_op_if opBus ();  // decode to execute

  // execute to result
  logic               stValid;
  lru_geom_pkg::setT  stSet;
  lru_geom_pkg::agesT stAges;

  lru_decode uDecode (
    .clk      (clk),
    .rstN     (rstN),
    .reqValid (reqValid),
    .reqOp    (reqOp),
    .reqSet   (reqSet),
    .reqWayA  (reqWayA),
    .reqWayB  (reqWayB),
    .op       (opBus.src)
  );

  lru_execute uExecute (
    .clk     (clk),
    .rstN    (rstN),
    .op      (opBus.dst),
    .stValid (stValid),
    .stSet   (stSet),
    .stAges  (stAges)
  );

  lru_result uResult (
    .clk       (clk),
    .rstN      (rstN),
    .stValid   (stValid),
    .stSet     (stSet),
    .stAges    (stAges),
    .rspValid  (rspValid),
    .rspSet    (rspSet),
    .rspVictim (rspVictim)
  );

endmodule

// File: verilog.f
source/lru_geom_pkg.sv
source/lru_op_pkg.sv
source/lru_op_if.sv
source/lru_decode.sv
source/lru_age_update.sv
source/lru_execute.sv
source/lru_result.sv
source/lru_top.sv
dv/lru_checker.sv
dv/lru_tb.sv
